// ==== verilog/dcache_geom_pkg.sv ====
`default_nettype none

package dcache_geom_pkg;

  ////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////

  // two ways, sixteen sets
  localparam int unsigned dcache_ways  = 2;
  localparam int unsigned dcache_off_w = 4;
  localparam int unsigned dcache_idx_w = 4;
  // tag takes what is left of 32 address bits
  localparam int unsigned dcache_tag_w = 32 - dcache_idx_w - dcache_off_w;
  // 16 byte line, 32 bit words
  localparam int unsigned dcache_words = 4;

  ////////////////////////////////////////
  // address and data vectors
  ////////////////////////////////////////

  typedef logic [dcache_tag_w-1:0] tag_t;
  typedef logic [dcache_idx_w-1:0] idx_t;
  typedef logic [dcache_off_w-1:0] off_t;
  typedef logic [31:0]             word_t;

  // full physical address, tag | index | offset
  typedef logic [dcache_tag_w+dcache_idx_w+dcache_off_w-1:0] paddr_t;

  // one bit per way
  // hit, valid and victim masks
  typedef logic [dcache_ways-1:0] way_mask_t;

  // word slot inside a line
  typedef logic [$clog2(dcache_words)-1:0] word_sel_t;

  // core transaction id
  typedef logic [3:0] req_id_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_mem_pkg.sv ====
`default_nettype none

package dcache_mem_pkg;

  // core access size
  typedef logic [1:0] size_t;
  localparam size_t size_byte = 2'd0;
  localparam size_t size_half = 2'd1;
  localparam size_t size_word = 2'd2;

  // access size for nc and all ones for a line
  typedef logic [2:0] miss_size_t;
  localparam miss_size_t msize_line = 3'b111;

  ////////////////////////////////////////
  // refill beats
  ////////////////////////////////////////

  // index of the final beat
  localparam dcache_geom_pkg::word_sel_t beat_last_line =
    dcache_geom_pkg::word_sel_t'(dcache_geom_pkg::dcache_words - 1);
  localparam dcache_geom_pkg::word_sel_t beat_last_word = '0;

endpackage

`default_nettype wire

// ==== verilog/dcache_rd_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface dcache_rd_if;
  import dcache_geom_pkg::*;

  // controller side
  logic      rd_req;
  idx_t      rd_idx;
  off_t      rd_off;
  // trails the index by one cycle
  tag_t      rd_tag;

  // array side
  logic      rd_ack;
  word_t     rd_data;
  way_mask_t rd_vld_bits;
  way_mask_t rd_hit_oh;
  // refill owns the arrays
  logic      wr_cl_vld;

  modport ctrl (
    output rd_req, rd_idx, rd_off, rd_tag,
    input  rd_ack, rd_data, rd_vld_bits, rd_hit_oh, wr_cl_vld
  );

  modport arr (
    input  rd_req, rd_idx, rd_off, rd_tag,
    output rd_ack, rd_data, rd_vld_bits, rd_hit_oh, wr_cl_vld
  );

endinterface

`default_nettype wire

// ==== verilog/dcache_miss_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface dcache_miss_if;
  import dcache_geom_pkg::*;
  import dcache_mem_pkg::*;

  // request level held until ack
  logic       miss_req;
  paddr_t     miss_paddr;
  logic       miss_nc;
  miss_size_t miss_size;
  // set valid bits seen at the miss
  way_mask_t  miss_vld_bits;

  // miss unit answers
  logic       miss_ack;
  logic       miss_rtrn_vld;
  word_t      miss_rtrn_data;

  modport ctrl (
    output miss_req, miss_paddr, miss_nc, miss_size, miss_vld_bits,
    input  miss_ack, miss_rtrn_vld, miss_rtrn_data
  );

  modport miss (
    input  miss_req, miss_paddr, miss_nc, miss_size, miss_vld_bits,
    output miss_ack, miss_rtrn_vld, miss_rtrn_data
  );

endinterface

`default_nettype wire

// ==== verilog/dcache_beat_cnt.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_beat_cnt (
  input  wire                              clk_i,
  input  wire                              arst_n_i,
  input  wire                              load_i,
  input  wire dcache_geom_pkg::word_sel_t  last_sel_i,
  input  wire                              step_i,
  output dcache_geom_pkg::word_sel_t       cnt_o,
  output logic                             last_o
);
  import dcache_geom_pkg::*;

  word_sel_t cnt_q;
  // final beat index of this refill
  word_sel_t last_q;

  assign cnt_o  = cnt_q;
  assign last_o = step_i && (cnt_q == last_q);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      last_q <= '0;
    end else if (load_i) begin
      cnt_q  <= '0;
      last_q <= last_sel_i;
    end else if (step_i) begin
      // wrap to zero after the final beat
      cnt_q <= last_o ? '0 : cnt_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_arrays.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_arrays (
  input  wire                              clk_i,
  input  wire                              arst_n_i,
  dcache_rd_if.arr                         rd,
  // refill write port
  input  wire                              wr_en_i,
  input  wire dcache_geom_pkg::way_mask_t  wr_way_i,
  input  wire dcache_geom_pkg::idx_t       wr_idx_i,
  input  wire dcache_geom_pkg::word_sel_t  wr_word_i,
  input  wire dcache_geom_pkg::word_t      wr_data_i,
  input  wire dcache_geom_pkg::tag_t       wr_tag_i,
  input  wire                              wr_vld_i
);
  import dcache_geom_pkg::*;

  localparam int unsigned Sets = 2 ** dcache_idx_w;

  tag_t      tag_mem  [Sets][dcache_ways];
  word_t     data_mem [Sets][dcache_ways][dcache_words];
  way_mask_t vld_mem  [Sets];

  idx_t      rd_idx_q;
  word_sel_t rd_word_q;
  way_mask_t hit_oh;
  word_t     data_mux;

  // refill wins the port
  assign rd.rd_ack    = rd.rd_req && !wr_en_i;
  assign rd.wr_cl_vld = wr_en_i;

  ////////////////////////////////////////
  // read side
  ////////////////////////////////////////

  // late tag compared against the set read last cycle
  always_comb begin
    data_mux = '0;
    for (int w = 0; w < dcache_ways; w++) begin
      hit_oh[w] = vld_mem[rd_idx_q][w] && (tag_mem[rd_idx_q][w] == rd.rd_tag);
      if (hit_oh[w]) begin
        data_mux = data_mux | data_mem[rd_idx_q][w][rd_word_q];
      end
    end
  end

  assign rd.rd_hit_oh   = hit_oh;
  assign rd.rd_data     = data_mux;
  assign rd.rd_vld_bits = vld_mem[rd_idx_q];

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rd.rd_req && rd.rd_ack) begin
      rd_idx_q  <= rd.rd_idx;
      rd_word_q <= rd.rd_off[dcache_off_w-1:2];
    end
    for (int w = 0; w < dcache_ways; w++) begin
      if (wr_en_i && wr_way_i[w]) begin
        data_mem[wr_idx_i][w][wr_word_i] <= wr_data_i;
        // tag goes in with word 0
        if (wr_vld_i) begin
          tag_mem[wr_idx_i][w] <= wr_tag_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < Sets; s++) begin
        vld_mem[s] <= '0;
      end
    end else if (wr_en_i && wr_vld_i) begin
      vld_mem[wr_idx_i] <= vld_mem[wr_idx_i] | wr_way_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_miss_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_miss_unit (
  input  wire                             clk_i,
  input  wire                             arst_n_i,
  dcache_miss_if.miss                     miss,
  // memory port
  output logic                            mem_req_o,
  output dcache_geom_pkg::paddr_t         mem_addr_o,
  output logic                            mem_nc_o,
  input  wire                             mem_gnt_i,
  input  wire                             mem_rvalid_i,
  input  wire dcache_geom_pkg::word_t     mem_rdata_i,
  // refill write
  output logic                            wr_en_o,
  output dcache_geom_pkg::way_mask_t      wr_way_o,
  output dcache_geom_pkg::idx_t           wr_idx_o,
  output dcache_geom_pkg::word_sel_t      wr_word_o,
  output dcache_geom_pkg::word_t          wr_data_o,
  output dcache_geom_pkg::tag_t           wr_tag_o,
  output logic                            wr_vld_o
);
  import dcache_geom_pkg::*;
  import dcache_mem_pkg::*;

  typedef enum logic [1:0] {MU_IDLE, MU_REQ, MU_BEATS} mu_state_e;

  mu_state_e state_d, state_q;
  paddr_t    paddr_q;
  logic      nc_q;
  way_mask_t way_q, victim;
  // round robin pointer for full sets
  logic      rr_q;
  word_sel_t cnt;
  logic      last, take, beat, req_beat;
  word_t     rdata_q;

  assign take = (state_q == MU_IDLE) && miss.miss_req;
  assign beat = (state_q == MU_BEATS) && mem_rvalid_i;
  // beat carrying the word the core asked for
  assign req_beat = beat && (nc_q || cnt == paddr_q[dcache_off_w-1:2]);

  // lowest invalid way first
  always_comb begin
    if (!miss.miss_vld_bits[0]) begin
      victim = way_mask_t'(2'b01);
    end else if (!miss.miss_vld_bits[1]) begin
      victim = way_mask_t'(2'b10);
    end else begin
      victim = rr_q ? way_mask_t'(2'b10) : way_mask_t'(2'b01);
    end
  end

  dcache_beat_cnt beat_cnt_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .load_i     (take),
    .last_sel_i ((miss.miss_size == msize_line) ? beat_last_line : beat_last_word),
    .step_i     (beat),
    .cnt_o      (cnt),
    .last_o     (last)
  );

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MU_IDLE:  if (take) state_d = MU_REQ;
      MU_REQ:   if (mem_gnt_i) state_d = MU_BEATS;
      MU_BEATS: if (last) state_d = MU_IDLE;
      default:  state_d = MU_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  assign miss.miss_ack       = take;
  assign miss.miss_rtrn_vld  = last;
  assign miss.miss_rtrn_data = req_beat ? mem_rdata_i : rdata_q;

  // word address for nc, line address otherwise
  assign mem_req_o  = (state_q == MU_REQ);
  assign mem_nc_o   = nc_q;
  assign mem_addr_o = nc_q ? {paddr_q[31:2], 2'b00} : {paddr_q[31:dcache_off_w], off_t'(0)};

  // nc beats never touch the arrays
  assign wr_en_o   = beat && !nc_q;
  assign wr_way_o  = way_q;
  assign wr_idx_o  = paddr_q[dcache_off_w +: dcache_idx_w];
  assign wr_word_o = cnt;
  assign wr_data_o = mem_rdata_i;
  assign wr_tag_o  = paddr_q[31 -: dcache_tag_w];
  assign wr_vld_o  = (cnt == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= MU_IDLE;
      nc_q    <= 1'b0;
      rr_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take) begin
        nc_q <= miss.miss_nc;
        // one toggle per allocation
        if (!miss.miss_nc) begin
          rr_q <= !rr_q;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      paddr_q <= miss.miss_paddr;
      way_q   <= victim;
    end
    if (req_beat) begin
      rdata_q <= mem_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_rd_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_rd_ctrl #(
  parameter dcache_geom_pkg::paddr_t CacheableBase = 32'h8000_0000,
  parameter dcache_geom_pkg::paddr_t CacheableMask = 32'hc000_0000
) (
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  // core request
  input  wire                            req_i,
  input  wire [dcache_geom_pkg::dcache_idx_w+dcache_geom_pkg::dcache_off_w-1:0] addr_index_i,
  input  wire dcache_geom_pkg::tag_t     addr_tag_i,
  input  wire                            tag_valid_i,
  input  wire                            kill_i,
  input  wire dcache_mem_pkg::size_t     size_i,
  input  wire dcache_geom_pkg::req_id_t  id_i,
  input  wire                            cache_en_i,
  // core response
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output dcache_geom_pkg::word_t         rdata_o,
  output dcache_geom_pkg::req_id_t       rid_o,
  output logic                           busy_o,
  // arrays and miss unit
  dcache_rd_if.ctrl                      rd,
  dcache_miss_if.ctrl                    miss
);
  import dcache_geom_pkg::*;
  import dcache_mem_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    MISS_REQ,
    MISS_WAIT,
    KILL_MISS,
    KILL_MISS_ACK,
    REPLAY_REQ,
    REPLAY_READ
  } rd_state_e;

  rd_state_e state_d, state_q;

  tag_t      tag_d, tag_q;
  idx_t      idx_d, idx_q;
  off_t      off_d, off_q;
  req_id_t   id_q;
  size_t     size_q;
  way_mask_t vld_q;
  logic      save_tag;
  // array took our read last cycle
  logic      rd_taken_q;
  logic      nc;

  // disabled cache or outside the region
  function automatic logic is_nc(input tag_t tag, input logic en);
    paddr_t addr;
    addr = {tag, {(dcache_idx_w + dcache_off_w){1'b0}}};
    return !en || ((addr & CacheableMask) != (CacheableBase & CacheableMask));
  endfunction

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////

  assign tag_d = save_tag ? addr_tag_i : tag_q;
  assign idx_d = gnt_o ? addr_index_i[dcache_idx_w+dcache_off_w-1:dcache_off_w] : idx_q;
  assign off_d = gnt_o ? addr_index_i[dcache_off_w-1:0] : off_q;

  // arrays see the new index in the grant cycle
  assign rd.rd_tag = tag_d;
  assign rd.rd_idx = idx_d;
  assign rd.rd_off = off_d;

  assign nc = is_nc(tag_d, cache_en_i);

  // miss request fields
  assign miss.miss_paddr    = {tag_q, idx_q, off_q};
  assign miss.miss_nc       = nc;
  assign miss.miss_size     = nc ? {1'b0, size_q} : msize_line;
  assign miss.miss_vld_bits = vld_q;

  // core response
  assign rid_o   = id_q;
  assign rdata_o = (state_q == MISS_WAIT) ? miss.miss_rtrn_data : rd.rd_data;
  assign busy_o  = (state_q != IDLE);

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    save_tag      = 1'b0;
    rd.rd_req     = 1'b0;
    miss.miss_req = 1'b0;
    gnt_o         = 1'b0;
    rvalid_o      = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          rd.rd_req = 1'b1;
          if (rd.rd_ack) begin
            gnt_o   = 1'b1;
            state_d = READ;
          end
        end
      end
      // hit check once the tag is there
      READ, REPLAY_READ: begin
        // keep the set read alive while waiting
        rd.rd_req = 1'b1;
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = IDLE;
        end else if (tag_valid_i || state_q == REPLAY_READ) begin
          save_tag = (state_q == READ);
          if (rd.wr_cl_vld || !rd_taken_q) begin
            // refill got in the way
            state_d = REPLAY_REQ;
          end else if ((|rd.rd_hit_oh) && !nc) begin
            rvalid_o = 1'b1;
            state_d  = IDLE;
            // back to back request
            if (req_i && rd.rd_ack) begin
              gnt_o   = 1'b1;
              state_d = READ;
            end
          end else begin
            state_d = MISS_REQ;
          end
        end
      end
      MISS_REQ: begin
        miss.miss_req = 1'b1;
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = miss.miss_ack ? KILL_MISS : KILL_MISS_ACK;
        end else if (miss.miss_ack) begin
          state_d = MISS_WAIT;
        end
      end
      // data comes with the last beat
      MISS_WAIT: begin
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = miss.miss_rtrn_vld ? IDLE : KILL_MISS;
        end else if (miss.miss_rtrn_vld) begin
          rvalid_o = 1'b1;
          state_d  = IDLE;
        end
      end
      REPLAY_REQ: begin
        rd.rd_req = 1'b1;
        if (kill_i) begin
          rvalid_o = 1'b1;
          state_d  = IDLE;
        end else if (rd.rd_ack) begin
          state_d = REPLAY_READ;
        end
      end
      // killed before ack, the request still has to go out
      KILL_MISS_ACK: begin
        miss.miss_req = 1'b1;
        if (miss.miss_ack) begin
          state_d = KILL_MISS;
        end
      end
      // line still being written
      KILL_MISS: begin
        if (miss.miss_rtrn_vld) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IDLE;
      rd_taken_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      rd_taken_q <= rd.rd_req && rd.rd_ack;
    end
  end

  always_ff @(posedge clk_i) begin
    tag_q <= tag_d;
    idx_q <= idx_d;
    off_q <= off_d;
    if (gnt_o) begin
      id_q   <= id_i;
      size_q <= size_i;
    end
    // valid bits follow the read by a cycle
    if (rd_taken_q) begin
      vld_q <= rd.rd_vld_bits;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
  parameter dcache_geom_pkg::paddr_t CacheableBase = 32'h8000_0000,
  parameter dcache_geom_pkg::paddr_t CacheableMask = 32'hc000_0000
) (
  input  wire                            clk_i,
  input  wire                            arst_n_i,
  // core side
  input  wire                            req_i,
  input  wire [dcache_geom_pkg::dcache_idx_w+dcache_geom_pkg::dcache_off_w-1:0] addr_index_i,
  input  wire dcache_geom_pkg::tag_t     addr_tag_i,
  input  wire                            tag_valid_i,
  input  wire                            kill_i,
  input  wire dcache_mem_pkg::size_t     size_i,
  input  wire dcache_geom_pkg::req_id_t  id_i,
  input  wire                            cache_en_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output dcache_geom_pkg::word_t         rdata_o,
  output dcache_geom_pkg::req_id_t       rid_o,
  output logic                           busy_o,
  // memory side
  output logic                           mem_req_o,
  output dcache_geom_pkg::paddr_t        mem_addr_o,
  output logic                           mem_nc_o,
  input  wire                            mem_gnt_i,
  input  wire                            mem_rvalid_i,
  input  wire dcache_geom_pkg::word_t    mem_rdata_i
);
  import dcache_geom_pkg::*;

  dcache_rd_if   rd_bus ();
  dcache_miss_if miss_bus ();

  // refill port, miss unit to arrays
  logic      wr_en;
  way_mask_t wr_way;
  idx_t      wr_idx;
  word_sel_t wr_word;
  word_t     wr_data;
  tag_t      wr_tag;
  logic      wr_vld;

  dcache_rd_ctrl #(
    .CacheableBase (CacheableBase),
    .CacheableMask (CacheableMask)
  ) rd_ctrl_inst (
    .clk_i, .arst_n_i,
    .req_i, .addr_index_i, .addr_tag_i, .tag_valid_i, .kill_i,
    .size_i, .id_i, .cache_en_i,
    .gnt_o, .rvalid_o, .rdata_o, .rid_o, .busy_o,
    .rd   (rd_bus.ctrl),
    .miss (miss_bus.ctrl)
  );

  dcache_arrays arrays_inst (
    .clk_i, .arst_n_i,
    .rd        (rd_bus.arr),
    .wr_en_i   (wr_en),
    .wr_way_i  (wr_way),
    .wr_idx_i  (wr_idx),
    .wr_word_i (wr_word),
    .wr_data_i (wr_data),
    .wr_tag_i  (wr_tag),
    .wr_vld_i  (wr_vld)
  );

  dcache_miss_unit miss_unit_inst (
    .clk_i, .arst_n_i,
    .miss (miss_bus.miss),
    .mem_req_o, .mem_addr_o, .mem_nc_o,
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i,
    .wr_en_o   (wr_en),
    .wr_way_o  (wr_way),
    .wr_idx_o  (wr_idx),
    .wr_word_o (wr_word),
    .wr_data_o (wr_data),
    .wr_tag_o  (wr_tag),
    .wr_vld_o  (wr_vld)
  );

endmodule

`default_nettype wire

// ==== dv/tb_dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dcache_top;
  import dcache_geom_pkg::*;
  import dcache_mem_pkg::*;

  // cacheable window 0x8000_0000 .. 0xbfff_ffff
  localparam paddr_t cache_base   = 32'h8000_0000;
  localparam paddr_t cache_mask   = 32'hc000_0000;
  localparam word_t  data_pattern = 32'h5a3c_96e1;

  localparam int clk_half     = 50;
  localparam int drv_dly      = 10;
  localparam int reset_cycles = 8;
  // about 20 reads plus kill and refill waits
  localparam int num_reads         = 24;
  // long tag delay, slow grant, four beats with gaps
  localparam int worst_read_cycles = 40;
  localparam int cycle_limit       = reset_cycles + num_reads * worst_read_cycles;

  logic                                 clk;
  logic                                 arst_n;
  logic                                 req;
  logic [dcache_idx_w+dcache_off_w-1:0] addr_index;
  tag_t                                 addr_tag;
  logic                                 tag_valid;
  logic                                 kill;
  size_t                                size;
  req_id_t                              id;
  logic                                 cache_en;
  logic                                 gnt;
  logic                                 rvalid;
  word_t                                rdata;
  req_id_t                              rid;
  logic                                 busy;
  logic                                 mem_req;
  paddr_t                               mem_addr;
  logic                                 mem_nc;
  logic                                 mem_gnt;
  logic                                 mem_rvalid;
  word_t                                mem_rdata;

  int     errors     = 0;
  int     cycles     = 0;
  int     mem_reqs   = 0;
  int     line_reqs  = 0;
  int     beats_done = 0;
  int     gnt_extra  = 0;
  integer seed       = 39507;

  // last memory request seen by the model
  paddr_t  last_addr;
  logic    last_nc;
  // last core response
  word_t   rd_word;
  req_id_t rd_id;
  int      rd_lat;
  logic    rd_beat;

  dcache_top #(
    .CacheableBase (cache_base),
    .CacheableMask (cache_mask)
  ) dcache_top_inst (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .req_i        (req),
    .addr_index_i (addr_index),
    .addr_tag_i   (addr_tag),
    .tag_valid_i  (tag_valid),
    .kill_i       (kill),
    .size_i       (size),
    .id_i         (id),
    .cache_en_i   (cache_en),
    .gnt_o        (gnt),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .rid_o        (rid),
    .busy_o       (busy),
    .mem_req_o    (mem_req),
    .mem_addr_o   (mem_addr),
    .mem_nc_o     (mem_nc),
    .mem_gnt_i    (mem_gnt),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  ////////////////////////////////////////
  // helpers and compare tasks
  ////////////////////////////////////////

  // memory word is its word address xor pattern
  function automatic word_t mem_word(input paddr_t addr);
    return word_t'(addr >> 2) ^ data_pattern;
  endfunction

  task automatic step();
    @(posedge clk);
    #drv_dly;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input paddr_t got, input paddr_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input req_id_t got, input req_id_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // memory model
  ////////////////////////////////////////

  initial begin : mem_model
    int delay;
    int beats;
    mem_gnt    = 1'b0;
    mem_rvalid = 1'b0;
    mem_rdata  = '0;
    forever begin
      step();
      if (mem_req) begin
        last_addr = mem_addr;
        last_nc   = mem_nc;
        mem_reqs++;
        if (!mem_nc) begin
          line_reqs++;
        end
        beats = mem_nc ? 1 : dcache_words;
        // grant after a short random wait
        delay = $unsigned($random(seed)) % 3 + gnt_extra;
        repeat (delay) step();
        mem_gnt = 1'b1;
        step();
        mem_gnt = 1'b0;
        // beats in order with random gaps
        for (int i = 0; i < beats; i++) begin
          delay = $unsigned($random(seed)) % 3;
          repeat (delay) step();
          mem_rvalid = 1'b1;
          mem_rdata  = mem_word(last_addr + 4 * i);
          beats_done++;
          step();
          mem_rvalid = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, run did not finish within %0d cycles", cycle_limit);
    $display("test failed");
    $finish;
  end

  ////////////////////////////////////////
  // core side
  ////////////////////////////////////////

  // tasks start and end at a falling edge
  task automatic grant_req(input paddr_t addr, input req_id_t req_id);
    step();
    req        = 1'b1;
    addr_index = addr[dcache_idx_w+dcache_off_w-1:0];
    id         = req_id;
    size       = size_word;
    @(negedge clk);
    while (!gnt) begin
      step();
      @(negedge clk);
    end
  endtask

  // tag comes tag_delay cycles after the grant
  task automatic finish_read(input paddr_t addr, input int tag_delay);
    rd_lat = 0;
    step();
    req = 1'b0;
    rd_lat++;
    repeat (tag_delay - 1) begin
      @(negedge clk);
      check_bit("rvalid_o", rvalid, 1'b0);
      step();
      rd_lat++;
    end
    tag_valid = 1'b1;
    addr_tag  = addr[31 -: dcache_tag_w];
    @(negedge clk);
    while (!rvalid) begin
      step();
      tag_valid = 1'b0;
      rd_lat++;
      @(negedge clk);
    end
    rd_word = rdata;
    rd_id   = rid;
    rd_beat = mem_rvalid;
    step();
    tag_valid = 1'b0;
    @(negedge clk);
    // one response per read, then idle
    check_bit("rvalid_o", rvalid, 1'b0);
    check_bit("busy_o", busy, 1'b0);
  endtask

  task automatic do_read(input paddr_t addr, input req_id_t req_id, input int tag_delay);
    grant_req(addr, req_id);
    finish_read(addr, tag_delay);
  endtask

  task automatic check_read(input paddr_t addr, input req_id_t req_id);
    check_word("rdata_o", rd_word, mem_word(addr));
    check_id("rid_o", rd_id, req_id);
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic test_cold_miss();
    int base;
    base = mem_reqs;
    do_read(32'h8001_2344, 4'h3, 1);
    check_read(32'h8001_2344, 4'h3);
    check_count("memory requests", mem_reqs - base, 1);
    check_addr("mem_addr_o", last_addr, 32'h8001_2340);
    check_bit("mem_nc_o", last_nc, 1'b0);
    check_bit("mem_rvalid_i", rd_beat, 1'b1);
    // same line, other word
    base = mem_reqs;
    do_read(32'h8001_234c, 4'h4, 1);
    check_read(32'h8001_234c, 4'h4);
    check_count("memory requests", mem_reqs - base, 0);
    check_count("hit latency", rd_lat, 1);
  endtask

  task automatic read_nc(input paddr_t addr, input req_id_t req_id);
    int base;
    base = mem_reqs;
    do_read(addr, req_id, 1);
    check_read(addr, req_id);
    check_count("memory requests", mem_reqs - base, 1);
    check_addr("mem_addr_o", last_addr, addr);
    check_bit("mem_nc_o", last_nc, 1'b1);
  endtask

  task automatic test_noncacheable();
    // outside the region, twice
    read_nc(32'h1000_0058, 4'h5);
    read_nc(32'h1000_0058, 4'h6);
    step();
    cache_en = 1'b0;
    @(negedge clk);
    read_nc(32'h8002_0060, 4'h7);
    read_nc(32'h8002_0060, 4'h8);
    step();
    cache_en = 1'b1;
    @(negedge clk);
  endtask

  task automatic test_replace();
    paddr_t a;
    paddr_t b;
    paddr_t c;
    paddr_t evicted;
    paddr_t kept;
    int     base;
    a = 32'h8100_0090;
    b = 32'h8200_0098;
    c = 32'h8300_009c;
    // a fills way 0 of the empty set and b fills way 1
    do_read(a, 4'h1, 1);
    check_read(a, 4'h1);
    do_read(b, 4'h2, 1);
    check_read(b, 4'h2);
    base = mem_reqs;
    do_read(a, 4'h9, 1);
    check_read(a, 4'h9);
    do_read(b, 4'ha, 1);
    check_read(b, 4'ha);
    check_count("memory requests", mem_reqs - base, 0);
    // round robin bit toggles once per line fill
    evicted = (line_reqs % 2) ? b : a;
    kept    = (line_reqs % 2) ? a : b;
    do_read(c, 4'hb, 1);
    check_read(c, 4'hb);
    base = mem_reqs;
    do_read(kept, 4'hc, 1);
    check_read(kept, 4'hc);
    check_count("memory requests", mem_reqs - base, 0);
    do_read(evicted, 4'hd, 1);
    check_read(evicted, 4'hd);
    check_count("memory requests", mem_reqs - base, 1);
  endtask

  task automatic test_kill();
    int base;
    int beat_base;
    // kill before the tag
    base = mem_reqs;
    grant_req(32'h8500_00b0, 4'h2);
    step();
    req  = 1'b0;
    kill = 1'b1;
    @(negedge clk);
    check_bit("rvalid_o", rvalid, 1'b1);
    step();
    kill = 1'b0;
    @(negedge clk);
    check_bit("busy_o", busy, 1'b0);
    repeat (6) begin
      step();
      @(negedge clk);
    end
    check_count("memory requests", mem_reqs - base, 0);
    // kill a miss while the line is on its way
    beat_base = beats_done;
    grant_req(32'h8600_00c4, 4'h3);
    step();
    req       = 1'b0;
    tag_valid = 1'b1;
    addr_tag  = 24'h860000;
    @(negedge clk);
    check_bit("rvalid_o", rvalid, 1'b0);
    step();
    tag_valid = 1'b0;
    @(negedge clk);
    while (!mem_req) begin
      step();
      @(negedge clk);
    end
    step();
    kill = 1'b1;
    @(negedge clk);
    check_bit("rvalid_o", rvalid, 1'b1);
    step();
    kill = 1'b0;
    @(negedge clk);
    while (busy) begin
      check_bit("rvalid_o", rvalid, 1'b0);
      step();
      @(negedge clk);
    end
    check_count("refill beats before busy_o fell", beats_done - beat_base, 4);
    // killed line was still written
    base = mem_reqs;
    do_read(32'h8600_00cc, 4'h4, 1);
    check_read(32'h8600_00cc, 4'h4);
    check_count("memory requests", mem_reqs - base, 0);
    check_count("hit latency", rd_lat, 1);
  endtask

  task automatic test_backpressure();
    int base;
    gnt_extra = 4;
    base = mem_reqs;
    do_read(32'h8700_00d8, 4'h5, 5);
    check_read(32'h8700_00d8, 4'h5);
    check_bit("mem_rvalid_i", rd_beat, 1'b1);
    do_read(32'h8700_00d0, 4'h6, 3);
    check_read(32'h8700_00d0, 4'h6);
    check_count("hit latency", rd_lat, 3);
    do_read(32'h2000_0100, 4'h7, 4);
    check_read(32'h2000_0100, 4'h7);
    check_count("memory requests", mem_reqs - base, 2);
    gnt_extra = 0;
  endtask

  initial begin : main
    arst_n     = 1'b0;
    req        = 1'b0;
    addr_index = '0;
    addr_tag   = '0;
    tag_valid  = 1'b0;
    kill       = 1'b0;
    size       = size_word;
    id         = '0;
    cache_en   = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #drv_dly;
    arst_n = 1'b1;
    @(negedge clk);
    check_bit("gnt_o", gnt, 1'b0);
    check_bit("rvalid_o", rvalid, 1'b0);
    check_bit("busy_o", busy, 1'b0);
    check_bit("mem_req_o", mem_req, 1'b0);
    test_cold_miss();
    test_noncacheable();
    test_replace();
    test_kill();
    test_backpressure();
    $display("errors: %0d, memory requests: %0d, cycles: %0d", errors, mem_reqs, cycles);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/dcache_geom_pkg.sv
verilog/dcache_mem_pkg.sv
verilog/dcache_rd_if.sv
verilog/dcache_miss_if.sv
verilog/dcache_beat_cnt.sv
verilog/dcache_arrays.sv
verilog/dcache_miss_unit.sv
verilog/dcache_rd_ctrl.sv
verilog/dcache_top.sv
dv/tb_dcache_top.sv

// ==== Bender.yml ====
package:
  name: dcache_rd

sources:
  - files:
      - verilog/dcache_geom_pkg.sv
      - verilog/dcache_mem_pkg.sv
      - verilog/dcache_rd_if.sv
      - verilog/dcache_miss_if.sv
      - verilog/dcache_beat_cnt.sv
      - verilog/dcache_arrays.sv
      - verilog/dcache_miss_unit.sv
      - verilog/dcache_rd_ctrl.sv
      - verilog/dcache_top.sv
  - target: test
    files:
      - dv/tb_dcache_top.sv
